// ==== fm_pac_testdata.txt ====
# op cart addr data expect; W write, R read (expect 100 = ROM model byte), S sink hold (data 1)
# F next FM entry, addr gives the port; F at addr 0000: data = pending entries, expect = {valid, overflow}
R 0 7FF6 00 00
R 0 7FF7 00 00
R 0 1FFE 00 FF
R 0 1FFF 00 FF
R 0 4000 00 100
W 0 7FF7 02 00
R 0 4123 00 100
R 0 7FF7 00 02
W 0 7FF6 FF 00
R 0 7FF6 00 11
W 0 7FF6 00 00
W 0 5FFE 4D 00
W 0 5FFF 69 00
R 0 5FFF 00 69
W 0 4010 A5 00
R 0 4010 00 A5
W 0 7FF6 10 00
R 0 4010 00 100
W 0 5FFE 4D 00
W 0 5FFF 69 00
R 0 5FFE 00 100
W 0 7FF6 01 00
W 0 5FFE 4D 00
W 0 5FFF 69 00
R 0 4010 00 A5
W 1 5FFE 4D 00
W 1 5FFF 69 00
W 1 4010 3C 00
R 1 4010 00 3C
R 1 7FF7 00 00
R 1 6000 00 100
R 0 6000 00 100
W 0 7FF4 10 00
W 0 7FF5 2B 00
F 0 7FF4 10 00
F 0 7FF5 2B 00
W 1 7FF5 66 00
F 0 0000 00 00
S 0 0000 01 00
W 0 7FF4 01 00
W 0 7FF5 02 00
W 0 7FF4 03 00
W 0 7FF5 04 00
W 0 7FF4 05 00
F 0 0000 00 11
S 0 0000 00 00
F 0 7FF4 01 00
F 0 7FF5 02 00
F 0 7FF4 03 00
F 0 7FF5 04 00
F 0 0000 00 01

// ==== vlog.f ====
msx_pkg.sv
fm_pac_mapper.sv
opll_write_queue.sv
cart_memory.sv
fm_pac_cart.sv
tb_fm_pac_cart.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FM-PAC cartridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_fm_pac_cart -Mdir obj_dir -o sim_fm_pac
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fm_pac > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tb_fm_pac_cart.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fm_pac_cart import msx_pkg::*;;

    logic                  clock_bus;
    logic                  rst_n;
    logic [0:0]            cart_sel;
    logic [addr_w-1:0]     addr;
    logic [7:0]            wdata;
    logic                  mreq;
    logic                  rd;
    logic                  wr;
    logic [7:0]            rdata;
    logic                  rdata_valid;
    logic                  rom_cs;
    logic [rom_addr_w-1:0] rom_addr;
    logic [7:0]            rom_data;
    logic                  opll_valid;
    logic                  opll_is_data;
    logic [7:0]            opll_data;
    logic                  opll_ready;
    logic                  opll_overflow;
    logic                  fm_enable;

    logic [1:0]            bank_model [2];   // Bank register as the CPU wrote it
    logic                  fm_model [2];     // FM enable bit as the CPU wrote it
    logic [8:0]            sink_q [$];       // {is_data, data} as accepted
    logic                  hold_ready;
    integer                seed;
    int                    limit_ns;

    fm_pac_cart #(
        .num_carts   (2),
        .queue_depth (4)
    ) dut0 (
        .clock_bus     (clock_bus),
        .rst_n         (rst_n),
        .cart_sel      (cart_sel),
        .addr          (addr),
        .wdata         (wdata),
        .mreq          (mreq),
        .rd            (rd),
        .wr            (wr),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .rom_cs        (rom_cs),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .opll_valid    (opll_valid),
        .opll_is_data  (opll_is_data),
        .opll_data     (opll_data),
        .opll_ready    (opll_ready),
        .opll_overflow (opll_overflow),
        .fm_enable     (fm_enable)
    );

    // ROM image: low address byte mixed with bank and cartridge
    function automatic logic [7:0] rom_byte(input logic c, input logic [1:0] b,
                                            input logic [7:0] lo);
        return lo ^ {2'b10, c, 3'b000, b};
    endfunction

    assign rom_data = rom_byte(cart_sel[0], rom_addr[15:14], rom_addr[7:0]);

    initial begin
        clock_bus = 1'b0;
        forever #4 clock_bus = ~clock_bus;
    end

    // Sound core sink with random back-pressure
    always @(posedge clock_bus) begin
        if (opll_valid && opll_ready)
            sink_q.push_back({opll_is_data, opll_data});
        #1;
        opll_ready = hold_ready ? 1'b0 : (($random(seed) & 3) != 0);
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Watchdog: the run did not finish within %0d ns and looks hung", limit_ns);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string what, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input logic c, input logic [15:0] a, input logic [7:0] d);
        @(posedge clock_bus);
        #1;
        cart_sel = c;
        addr     = a;
        wdata    = d;
        mreq     = 1'b1;
        wr       = 1'b1;
        #2;
        check_value($sformatf("rom_cs on write to %h", a), {15'd0, rom_cs}, 16'd0);
        check_value($sformatf("fm_enable cart %0d", c), {15'd0, fm_enable},
                    {15'd0, fm_model[c]});
        @(posedge clock_bus);    // Write lands here
        #1;
        mreq = 1'b0;
        wr   = 1'b0;
        if (a[13:0] == reg_bank)
            bank_model[c] = d[1:0];
        if (a[13:0] == reg_ctrl)
            fm_model[c] = d[0];
    endtask

    task automatic bus_read(input logic c, input logic [15:0] a, input logic [31:0] e);
        int         lat;
        logic [7:0] exp_byte;
        logic       exp_cs;
        exp_byte = (e == 32'h100) ? rom_byte(c, bank_model[c], a[7:0]) : e[7:0];
        // Page 1 reads select the ROM unless the byte comes from SRAM
        exp_cs   = (a[15:14] == 2'b01) && ((e == 32'h100) || (a[13:0] >= reg_magic_lo));
        @(posedge clock_bus);
        #1;
        cart_sel = c;
        addr     = a;
        mreq     = 1'b1;
        rd       = 1'b1;
        #2;
        check_value($sformatf("rom_cs on read of %h", a), {15'd0, rom_cs}, {15'd0, exp_cs});
        check_value($sformatf("fm_enable cart %0d", c), {15'd0, fm_enable},
                    {15'd0, fm_model[c]});
        @(posedge clock_bus);
        #1;
        mreq = 1'b0;
        rd   = 1'b0;
        lat  = 1;
        while (!rdata_valid) begin
            @(posedge clock_bus);
            #1;
            lat++;
        end
        check_value($sformatf("read latency at %h", a), 16'(lat), 16'd1);
        check_value($sformatf("read data cart %0d addr %h", c, a), {8'h00, rdata},
                    {8'h00, exp_byte});
    endtask

    // Next accepted FM entry, in order
    task automatic fm_expect(input logic [15:0] a, input logic [7:0] d);
        logic [8:0] entry;
        while (sink_q.size() == 0) begin
            @(posedge clock_bus);
            #2;
        end
        entry = sink_q.pop_front();
        check_value("FM entry port flag", {15'd0, entry[8]}, {15'd0, a[0]});
        check_value("FM entry data", {8'h00, entry[7:0]}, {8'h00, d});
    endtask

    task automatic queue_status(input logic [7:0] pending, input logic [7:0] flags);
        repeat (3) @(posedge clock_bus);
        #2;
        check_value("unchecked FM entries", 16'(sink_q.size()), {8'h00, pending});
        check_value("valid/overflow", {8'h00, 3'b000, opll_valid, 3'b000, opll_overflow},
                    {8'h00, flags});
    endtask

    initial begin : stimulus
        int          fd;
        int          n;
        int          n_lines;
        string       line;
        logic [7:0]  op;
        logic [31:0] f_cart;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        rst_n         = 1'b0;
        cart_sel      = '0;
        addr          = '0;
        wdata         = '0;
        mreq          = 1'b0;
        rd            = 1'b0;
        wr            = 1'b0;
        opll_ready    = 1'b0;
        hold_ready    = 1'b0;
        seed          = 32'h9af8;
        bank_model[0] = '0;
        bank_model[1] = '0;
        fm_model[0]   = 1'b0;
        fm_model[1]   = 1'b0;
        limit_ns      = 0;
        n_lines       = 0;
        fd = $fopen("fm_pac_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open fm_pac_testdata.txt for reading");
            $display("TEST FAILED");
            $fatal(1, "missing stimulus file");
        end
        while ($fgets(line, fd) > 0)
            n_lines++;
        $fclose(fd);
        limit_ns = (n_lines + 4) * 20 * 8;   // 20 cycles per line
        fd = $fopen("fm_pac_testdata.txt", "r");
        repeat (2) @(posedge clock_bus);
        #1 rst_n = 1'b1;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line[0] == "#")
                continue;
            op = line[0];
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                        f_cart, f_addr, f_data, f_exp);
            if (n != 4) begin
                $display("Malformed stimulus line: %s", line);
                $display("TEST FAILED");
                $fatal(1, "bad stimulus");
            end
            case (op)
                "W": bus_write(f_cart[0], f_addr[15:0], f_data[7:0]);
                "R": bus_read(f_cart[0], f_addr[15:0], f_exp);
                "S": hold_ready = f_data[0];
                "F": begin
                    if (f_addr == 0)
                        queue_status(f_data[7:0], f_exp[7:0]);
                    else
                        fm_expect(f_addr[15:0], f_data[7:0]);
                end
                default: begin
                    $display("Unknown operation in stimulus line: %s", line);
                    $display("TEST FAILED");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end
        $fclose(fd);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fm_pac_cart.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_pac_cart import msx_pkg::*; #(
    parameter int num_carts   = 2,
    parameter int queue_depth = 4,
    parameter int sel_w       = (num_carts > 1) ? $clog2(num_carts) : 1
) (
    input  wire logic                  clock_bus,
    input  wire logic                  rst_n,
    // CPU side
    input  wire logic [sel_w-1:0]      cart_sel,
    input  wire logic [addr_w-1:0]     addr,
    input  wire logic [7:0]            wdata,
    input  wire logic                  mreq,
    input  wire logic                  rd,
    input  wire logic                  wr,
    output logic [7:0]                 rdata,
    output logic                       rdata_valid,
    // External ROM
    output logic                       rom_cs,
    output logic [rom_addr_w-1:0]      rom_addr,
    input  wire logic [7:0]            rom_data,
    // Sound core
    output logic                       opll_valid,
    output logic                       opll_is_data,
    output logic [7:0]                 opll_data,
    input  wire logic                  opll_ready,
    output logic                       opll_overflow,
    output logic                       fm_enable
);

    logic                   sram_cs;
    logic                   sram_we;
    logic [sram_addr_w-1:0] sram_addr;
    logic                   reg_hit;
    logic [7:0]             reg_rdata;
    logic                   opll_wr;
    logic                   map_is_data;   // Port flag before the queue
    logic [7:0]             opll_wdata;

    fm_pac_mapper #(
        .num_carts (num_carts),
        .sel_w     (sel_w)
    ) u_mapper (
        .clock_bus    (clock_bus),
        .rst_n        (rst_n),
        .cart_sel     (cart_sel),
        .addr         (addr),
        .wdata        (wdata),
        .mreq         (mreq),
        .rd           (rd),
        .wr           (wr),
        .sram_cs      (sram_cs),
        .sram_we      (sram_we),
        .sram_addr    (sram_addr),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .reg_hit      (reg_hit),
        .reg_rdata    (reg_rdata),
        .opll_wr      (opll_wr),
        .opll_is_data (map_is_data),
        .opll_wdata   (opll_wdata),
        .fm_enable    (fm_enable)
    );

    opll_write_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clock_bus        (clock_bus),
        .rst_n            (rst_n),
        .opll_wr          (opll_wr),
        .opll_is_data     (map_is_data),
        .opll_wdata       (opll_wdata),
        .opll_ready       (opll_ready),
        .opll_valid       (opll_valid),
        .opll_is_data_out (opll_is_data),
        .opll_data        (opll_data),
        .opll_overflow    (opll_overflow)
    );

    cart_memory #(
        .num_carts (num_carts),
        .sel_w     (sel_w)
    ) u_memory (
        .clock_bus   (clock_bus),
        .rst_n       (rst_n),
        .cart_sel    (cart_sel),
        .sram_cs     (sram_cs),
        .sram_we     (sram_we),
        .sram_addr   (sram_addr),
        .wdata       (wdata),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .reg_hit     (reg_hit),
        .reg_rdata   (reg_rdata),
        .rd          (rd),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// ==== cart_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_memory import msx_pkg::*; #(
    parameter int num_carts = 2,
    parameter int sel_w     = (num_carts > 1) ? $clog2(num_carts) : 1
) (
    input  wire logic                   clock_bus,
    input  wire logic                   rst_n,
    input  wire logic [sel_w-1:0]       cart_sel,
    input  wire logic                   sram_cs,
    input  wire logic                   sram_we,
    input  wire logic [sram_addr_w-1:0] sram_addr,
    input  wire logic [7:0]             wdata,
    input  wire logic                   rom_cs,
    input  wire logic [7:0]             rom_data,
    input  wire logic                   reg_hit,
    input  wire logic [7:0]             reg_rdata,
    input  wire logic                   rd,
    output logic [7:0]                  rdata,
    output logic                        rdata_valid
);

    localparam int mem_depth = num_carts << sram_addr_w;

    // One 8 KB bank per cartridge, cartridge number on top
    logic [7:0]                   sram_mem [mem_depth];
    logic [sel_w+sram_addr_w-1:0] mem_idx;
    logic [7:0]                   rd_byte;

    assign mem_idx = {cart_sel, sram_addr};

    always_ff @(posedge clock_bus) begin
        if (sram_we)
            sram_mem[mem_idx] <= wdata;
    end

    // Source priority: SRAM, registers, ROM, open bus
    always_comb begin
        if (sram_cs)
            rd_byte = sram_mem[mem_idx];
        else if (reg_hit)
            rd_byte = reg_rdata;
        else if (rom_cs)
            rd_byte = rom_data;
        else
            rd_byte = 8'hFF;
    end

    always_ff @(posedge clock_bus) begin
        if (rd)
            rdata <= rd_byte;
    end

    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n)
            rdata_valid <= 1'b0;
        else
            rdata_valid <= rd;                 // One-cycle read latency
    end

    // SRAM window ends below the register offsets
    a_sram_reg_apart: assert property (@(posedge clock_bus) disable iff (!rst_n)
        !(sram_cs && reg_hit));

endmodule

`default_nettype wire

// ==== opll_write_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module opll_write_queue #(
    parameter int queue_depth = 4
) (
    input  wire logic       clock_bus,
    input  wire logic       rst_n,
    input  wire logic       opll_wr,
    input  wire logic       opll_is_data,
    input  wire logic [7:0] opll_wdata,
    input  wire logic       opll_ready,
    output logic            opll_valid,
    output logic            opll_is_data_out,
    output logic [7:0]      opll_data,
    output logic            opll_overflow
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    logic [7:0]       data_mem    [queue_depth];
    logic             is_data_mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(queue_depth - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign full       = (count == cnt_w'(queue_depth));
    assign opll_valid = (count != '0);
    assign push       = opll_wr && !full;      // A full queue drops the write
    assign pop        = opll_valid && opll_ready;

    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            opll_overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (opll_wr && full)
                opll_overflow <= 1'b1;          // Sticky until reset
        end
    end

    always_ff @(posedge clock_bus) begin
        if (push) begin
            data_mem[wr_ptr]    <= opll_wdata;
            is_data_mem[wr_ptr] <= opll_is_data;
        end
    end

    assign opll_data        = data_mem[rd_ptr];
    assign opll_is_data_out = is_data_mem[rd_ptr];

    a_hold_stable: assert property (@(posedge clock_bus) disable iff (!rst_n)
        opll_valid && !opll_ready |=>
            opll_valid && $stable(opll_data) && $stable(opll_is_data_out));

    a_count_max: assert property (@(posedge clock_bus) disable iff (!rst_n)
        count <= cnt_w'(queue_depth));

endmodule

`default_nettype wire

// ==== fm_pac_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_pac_mapper import msx_pkg::*; #(
    parameter int num_carts = 2,
    parameter int sel_w     = (num_carts > 1) ? $clog2(num_carts) : 1
) (
    input  wire logic                   clock_bus,
    input  wire logic                   rst_n,
    input  wire logic [sel_w-1:0]       cart_sel,
    input  wire logic [addr_w-1:0]      addr,
    input  wire logic [7:0]             wdata,
    input  wire logic                   mreq,
    input  wire logic                   rd,
    input  wire logic                   wr,
    output logic                        sram_cs,
    output logic                        sram_we,
    output logic [sram_addr_w-1:0]      sram_addr,
    output logic                        rom_cs,
    output logic [rom_addr_w-1:0]       rom_addr,
    output logic                        reg_hit,
    output logic [7:0]                  reg_rdata,
    output logic                        opll_wr,
    output logic                        opll_is_data,
    output logic [7:0]                  opll_wdata,
    output logic                        fm_enable
);

    localparam int         page_w    = 14;
    localparam int         bank_w    = rom_addr_w - page_w;
    localparam logic [7:0] ctrl_mask = 8'h11;   // Only fm_en and sram_lock are kept

    fm_pac_ctrl_u       ctrl_q   [num_carts];
    logic [bank_w-1:0]  bank_q   [num_carts];
    logic [7:0]         magic_lo [num_carts];
    logic [7:0]         magic_hi [num_carts];

    logic [page_w-1:0]  offset;
    logic               cpu_wr;
    logic               unlocked;
    logic               in_page1;
    fm_pac_ctrl_u       ctrl_new;

    assign offset   = addr[page_w-1:0];
    assign cpu_wr   = mreq && wr;
    assign in_page1 = (addr[addr_w-1:page_w] == 2'b01);
    assign unlocked = ({magic_hi[cart_sel], magic_lo[cart_sel]} == sram_magic);
    assign ctrl_new.raw = wdata & ctrl_mask;

    // Register file of the selected cartridge
    always_ff @(posedge clock_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_carts; i++) begin
                ctrl_q[i]   <= '0;
                bank_q[i]   <= '0;
                magic_lo[i] <= '0;
                magic_hi[i] <= '0;
            end
        end else if (cpu_wr) begin
            case (offset)
                reg_magic_lo: begin
                    if (!ctrl_q[cart_sel].f.sram_lock)
                        magic_lo[cart_sel] <= wdata;
                end
                reg_magic_hi: begin
                    if (!ctrl_q[cart_sel].f.sram_lock)
                        magic_hi[cart_sel] <= wdata;
                end
                reg_ctrl: begin
                    ctrl_q[cart_sel] <= ctrl_new;
                    if (ctrl_new.f.sram_lock) begin   // Locking wipes the magic word
                        magic_lo[cart_sel] <= '0;
                        magic_hi[cart_sel] <= '0;
                    end
                end
                reg_bank: bank_q[cart_sel] <= wdata[bank_w-1:0];
                default: ;
            endcase
        end
    end

    // Memory selects
    assign sram_cs   = unlocked && (offset < reg_magic_lo) && mreq && (rd || wr);
    assign sram_we   = sram_cs && wr;
    assign sram_addr = addr[sram_addr_w-1:0];
    assign rom_cs    = mreq && rd && in_page1 && !sram_cs;
    assign rom_addr  = {bank_q[cart_sel], offset};

    // FM chip port writes go straight to the queue
    assign fm_enable    = ctrl_q[cart_sel].f.fm_en;
    assign opll_wr      = cpu_wr && fm_enable &&
                          ((offset == reg_opll_addr) || (offset == reg_opll_data));
    assign opll_is_data = addr[0];            // 0x3FF5 is the data port
    assign opll_wdata   = wdata;

    // Register readback
    always_comb begin
        reg_hit   = 1'b0;
        reg_rdata = 8'hFF;
        if (mreq && rd) begin
            case (offset)
                reg_ctrl: begin
                    reg_hit   = 1'b1;
                    reg_rdata = ctrl_q[cart_sel].raw;
                end
                reg_bank: begin
                    reg_hit   = 1'b1;
                    reg_rdata = {{(8 - bank_w){1'b0}}, bank_q[cart_sel]};
                end
                reg_magic_lo: begin
                    reg_hit   = unlocked;   // Magic bytes visible only while open
                    reg_rdata = magic_lo[cart_sel];
                end
                reg_magic_hi: begin
                    reg_hit   = unlocked;
                    reg_rdata = magic_hi[cart_sel];
                end
                default: ;
            endcase
        end
    end

    // A set lock bit keeps the magic word cleared
    a_lock_clears_magic: assert property (@(posedge clock_bus) disable iff (!rst_n)
        ctrl_q[cart_sel].f.sram_lock |->
            ({magic_hi[cart_sel], magic_lo[cart_sel]} == 16'h0000));

endmodule

`default_nettype wire

// ==== msx_pkg.sv ====
`default_nettype none

package msx_pkg;

    // Bus widths
    localparam int addr_w      = 16;
    localparam int rom_addr_w  = 16;          // 2 bank bits + 14 offset bits
    localparam int sram_addr_w = 13;          // 8 KB window

    // Register offsets inside the 16 KB page
    localparam logic [13:0] reg_magic_lo  = 14'h1FFE;
    localparam logic [13:0] reg_magic_hi  = 14'h1FFF;
    localparam logic [13:0] reg_opll_addr = 14'h3FF4;
    localparam logic [13:0] reg_opll_data = 14'h3FF5;
    localparam logic [13:0] reg_ctrl      = 14'h3FF6;
    localparam logic [13:0] reg_bank      = 14'h3FF7;

    // Value that opens the battery SRAM window
    localparam logic [15:0] sram_magic = 16'h694D;

    // Control register, written as a byte and decoded by field
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] rsvd_hi;    // Always zero
            logic       sram_lock;  // Freezes the magic registers
            logic [2:0] rsvd_lo;    // Always zero
            logic       fm_en;      // FM chip enable
        } f;
    } fm_pac_ctrl_u;

endpackage

`default_nettype wire
